//--- sim/pipeline_cases.txt
# Tag I: program word in hex, placed from RESET_PC upward; tag L: data address and preload
# Tag S: expected store address and data in program order; text after the values is a remark
I 3C011234 # 00 lui   $1, 0x1234
I 34215678 # 04 ori   $1, $1, 0x5678
I 2422FFF8 # 08 addiu $2, $1, -8
I 00411823 # 0c subu  $3, $2, $1
I 00612024 # 10 and   $4, $3, $1
I 00832825 # 14 or    $5, $4, $3
I 00A4302A # 18 slt   $6, $5, $4
I 00C53821 # 1c addu  $7, $6, $5
I AC070100 # 20 sw    $7, 0x100($0)
I AC060104 # 24 sw    $6, 0x104($0)
I AC030108 # 28 sw    $3, 0x108($0)
I 0085402A # 2c slt   $8, $4, $5
I AC08010C # 30 sw    $8, 0x10c($0)
I 8C090080 # 34 lw    $9, 0x80($0)
I 01215021 # 38 addu  $10, $9, $1   load-use stall
I AC0A0110 # 3c sw    $10, 0x110($0)
I 24000055 # 40 addiu $0, $0, 0x55
I AC000114 # 44 sw    $0, 0x114($0)
I 10210002 # 48 beq   $1, $1, 0x54  taken
I AC0101F0 # 4c sw    $1, 0x1f0($0) skipped
I AC0101F0 # 50 sw    $1, 0x1f0($0) skipped
I 14220001 # 54 bne   $1, $2, 0x5c  taken
I AC0101F0 # 58 sw    $1, 0x1f0($0) skipped
I 10220001 # 5c beq   $1, $2, 0x64  not taken
I AC020118 # 60 sw    $2, 0x118($0)
I 14630001 # 64 bne   $3, $3, 0x6c  not taken
I AC04011C # 68 sw    $4, 0x11c($0)
I 0800001D # 6c j     0x74
I AC0101F0 # 70 sw    $1, 0x1f0($0) skipped
I 240B0003 # 74 addiu $11, $0, 3
I 240C0120 # 78 addiu $12, $0, 0x120
I AD8B0000 # 7c sw    $11, 0($12)   loop head
I 258C0004 # 80 addiu $12, $12, 4
I 256BFFFF # 84 addiu $11, $11, -1
I 15600001 # 88 bne   $11, $0, 0x90
I 08000026 # 8c j     0x98          loop exit
I 0800001F # 90 j     0x7c
I AC0101F0 # 94 sw    $1, 0x1f0($0) skipped
I AC0C0130 # 98 sw    $12, 0x130($0)
I 08000027 # 9c j     0x9c          park
L 00000080 00001111
S 00000100 FFFFFFF9
S 00000104 00000001
S 00000108 FFFFFFF8
S 0000010C 00000000
S 00000110 12346789
S 00000114 00000000
S 00000118 12345670
S 0000011C 12345678
S 00000120 00000003
S 00000124 00000002
S 00000128 00000001
S 00000130 0000012C

//--- flist.f
design/cpu_pkg.sv
design/fetch_stage.sv
design/decoder.sv
design/reg_file.sv
design/forward_unit.sv
design/execute_stage.sv
design/hazard_unit.sv
design/pipeline.sv
sim/pipeline_tb.sv

//--- Bender.yml
package:
  name: pipeline

sources:
  - design/cpu_pkg.sv
  - design/fetch_stage.sv
  - design/decoder.sv
  - design/reg_file.sv
  - design/forward_unit.sv
  - design/execute_stage.sv
  - design/hazard_unit.sv
  - design/pipeline.sv
  - target: test
    files:
      - sim/pipeline_tb.sv

//--- sim/pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb;

    // Instruction memory decodes address bits 9:2 only, so jump targets alias into the program
    localparam cpu_pkg::pc_t RESET_PC   = 32'h0000_0400;
    localparam int           MEM_WORDS  = 256;
    localparam int           WAIT_LIMIT = 2000;

    logic               clk;
    logic               reset;
    cpu_pkg::pc_t       imem_addr;
    cpu_pkg::instr_t    imem_data;
    cpu_pkg::dmem_req_t dmem_req;
    cpu_pkg::data_t     dmem_rdata;

    cpu_pkg::instr_t imem [0:MEM_WORDS-1];
    cpu_pkg::data_t  dmem [0:MEM_WORDS-1];

    // Expected stores in program order
    cpu_pkg::data_t exp_addr_q [$];
    cpu_pkg::data_t exp_data_q [$];

    pipeline #(
        .RESET_PC ( RESET_PC )
    ) dut_i (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .imem_addr  ( imem_addr  ),
        .imem_data  ( imem_data  ),
        .dmem_req   ( dmem_req   ),
        .dmem_rdata ( dmem_rdata )
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    // Both memories answer in the same cycle, data memory only on a read
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = (dmem_req.read === 1'b1) ? dmem[dmem_req.addr[9:2]] : 'x;

    always @(posedge clk) begin
        if (dmem_req.write === 1'b1) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic load_cases;
        integer           fd;
        integer           code;
        integer           word_idx;
        logic [63:0]      tag;
        logic [31:0]      val_a;
        logic [31:0]      val_b;
        logic [8*256-1:0] rest;
        fd = $fopen("sim/pipeline_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file sim/pipeline_cases.txt");
            $display("test failed");
            $fatal(1, "no stimulus");
        end
        word_idx = int'(RESET_PC[9:2]);
        code     = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "I") begin
                code = $fscanf(fd, "%h", val_a);
                imem[word_idx] = val_a;
                word_idx++;
            end else if (tag == "L") begin
                code = $fscanf(fd, "%h %h", val_a, val_b);
                dmem[val_a[9:2]] = val_b;
            end else if (tag == "S") begin
                code = $fscanf(fd, "%h %h", val_a, val_b);
                exp_addr_q.push_back(val_a);
                exp_data_q.push_back(val_b);
            end else if (tag != "#") begin
                $display("Unknown line tag %s in the case file", tag);
                $display("test failed");
                $fatal(1, "bad case file");
            end
            // Whatever follows on the line is a remark
            code = $fgets(rest, fd);
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
    endtask

    task automatic wait_for_store(input int idx);
        int   cycles;
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            seen = (dmem_req.write === 1'b1);
            cycles++;
        end
        if (!seen) begin
            $display("Timeout: store %0d to address %h never came within %0d cycles",
                     idx, exp_addr_q[idx], WAIT_LIMIT);
            $display("test failed");
            $fatal(1, "pipeline stopped storing");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int i;
        clk   = 1'b0;
        reset = 1'b1;
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        load_cases();

        // No memory request while reset lasts
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            check_value({31'd0, dmem_req.write}, 32'd0, "store strobe during reset");
            check_value({31'd0, dmem_req.read}, 32'd0, "load strobe during reset");
        end
        reset = 1'b0;
        check_value(imem_addr, RESET_PC, "first fetch address after reset");

        // Pipeline still filling
        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            check_value({31'd0, dmem_req.write}, 32'd0, "store strobe right after reset");
            check_value({31'd0, dmem_req.read}, 32'd0, "load strobe right after reset");
        end

        for (i = 0; i < exp_addr_q.size(); i++) begin
            wait_for_store(i);
            check_value(dmem_req.addr, exp_addr_q[i], $sformatf("address of store %0d", i));
            check_value(dmem_req.wdata, exp_data_q[i], $sformatf("data of store %0d", i));
        end

        // Program parks in a self loop
        for (i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            check_value({31'd0, dmem_req.write}, 32'd0, "store after the last expected one");
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline #(
    parameter cpu_pkg::pc_t RESET_PC = '0
) (
    input  wire                  clk,
    input  wire                  reset,
    output cpu_pkg::pc_t         imem_addr,
    input  wire cpu_pkg::instr_t imem_data,
    output cpu_pkg::dmem_req_t   dmem_req,
    input  wire cpu_pkg::data_t  dmem_rdata
);

    // IF/ID and decode
    cpu_pkg::instr_t    ifid_instr;
    cpu_pkg::pc_t       ifid_pc_4;
    cpu_pkg::ctrl_t     id_ctrl;
    cpu_pkg::data_t     id_imm;
    cpu_pkg::reg_addr_t id_rs_addr;
    cpu_pkg::reg_addr_t id_rt_addr;
    cpu_pkg::reg_addr_t id_rd_addr;
    cpu_pkg::pc_t       id_jump_target;
    cpu_pkg::data_t     id_rs_data;
    cpu_pkg::data_t     id_rt_data;

    // Later stages
    cpu_pkg::idex_t     idex;
    cpu_pkg::exmem_t    exmem;
    logic               redirect;
    cpu_pkg::pc_t       redirect_target;
    logic               stall;
    logic               ifid_flush;
    logic               idex_flush;

    // MEM/WB register
    logic               wb_reg_write;
    logic               wb_mem_read;
    cpu_pkg::reg_addr_t wb_rd_addr;
    cpu_pkg::data_t     wb_alu_res;
    cpu_pkg::data_t     wb_mem_data;
    cpu_pkg::wb_t       wb;

    //////////////////////////////////////////////////////////////////////
    // IF and ID
    //////////////////////////////////////////////////////////////////////

    fetch_stage #(
        .RESET_PC ( RESET_PC )
    ) fetch_i (
        .clk             ( clk             ),
        .reset           ( reset           ),
        .stall           ( stall           ),
        .flush           ( ifid_flush      ),
        .jump            ( id_ctrl.jump    ),
        .jump_target     ( id_jump_target  ),
        .redirect        ( redirect        ),
        .redirect_target ( redirect_target ),
        .imem_data       ( imem_data       ),
        .imem_addr       ( imem_addr       ),
        .ifid_instr      ( ifid_instr      ),
        .ifid_pc_4       ( ifid_pc_4       )
    );

    decoder decoder_i (
        .instr       ( ifid_instr     ),
        .pc_4        ( ifid_pc_4      ),
        .ctrl        ( id_ctrl        ),
        .imm         ( id_imm         ),
        .rs_addr     ( id_rs_addr     ),
        .rt_addr     ( id_rt_addr     ),
        .rd_addr     ( id_rd_addr     ),
        .jump_target ( id_jump_target )
    );

    reg_file reg_file_i (
        .clk     ( clk        ),
        .reset   ( reset      ),
        .wb      ( wb         ),
        .rs_addr ( id_rs_addr ),
        .rt_addr ( id_rt_addr ),
        .rs_data ( id_rs_data ),
        .rt_data ( id_rt_data )
    );

    hazard_unit hazard_i (
        .idex_mem_read ( idex.ctrl.mem_read ),
        .idex_rd_addr  ( idex.rd_addr       ),
        .rs_addr       ( id_rs_addr         ),
        .rt_addr       ( id_rt_addr         ),
        .jump          ( id_ctrl.jump       ),
        .redirect      ( redirect           ),
        .stall         ( stall              ),
        .ifid_flush    ( ifid_flush         ),
        .idex_flush    ( idex_flush         )
    );

    // Bubble is all controls low
    always_ff @(posedge clk) begin
        if (reset || idex_flush) begin
            idex.ctrl <= '0;
        end else begin
            idex.ctrl <= id_ctrl;
        end
        idex.pc_4    <= ifid_pc_4;
        idex.rs_data <= id_rs_data;
        idex.rt_data <= id_rt_data;
        idex.imm     <= id_imm;
        idex.rs_addr <= id_rs_addr;
        idex.rt_addr <= id_rt_addr;
        idex.rd_addr <= id_rd_addr;
    end

    //////////////////////////////////////////////////////////////////////
    // EX, MEM and WB
    //////////////////////////////////////////////////////////////////////

    execute_stage execute_i (
        .clk             ( clk             ),
        .reset           ( reset           ),
        .idex            ( idex            ),
        .wb              ( wb              ),
        .exmem           ( exmem           ),
        .redirect        ( redirect        ),
        .redirect_target ( redirect_target )
    );

    always_comb begin
        dmem_req.read  = exmem.mem_read;
        dmem_req.write = exmem.mem_write;
        dmem_req.addr  = exmem.alu_res;
        dmem_req.wdata = exmem.store_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg_write <= 1'b0;
            wb_mem_read  <= 1'b0;
        end else begin
            wb_reg_write <= exmem.reg_write;
            wb_mem_read  <= exmem.mem_read;
        end
        wb_rd_addr  <= exmem.rd_addr;
        wb_alu_res  <= exmem.alu_res;
        wb_mem_data <= dmem_rdata;
    end

    // Loads write memory data, everything else the ALU result
    always_comb begin
        wb.reg_write = wb_reg_write;
        wb.rd_addr   = wb_rd_addr;
        wb.data      = wb_mem_read ? wb_mem_data : wb_alu_res;
    end

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire                     idex_mem_read,
    input  wire cpu_pkg::reg_addr_t idex_rd_addr,
    input  wire cpu_pkg::reg_addr_t rs_addr,
    input  wire cpu_pkg::reg_addr_t rt_addr,
    input  wire                     jump,
    input  wire                     redirect,
    output logic                    stall,
    output logic                    ifid_flush,
    output logic                    idex_flush
);

    // Load in EX feeding the instruction in ID
    assign stall = idex_mem_read && idex_rd_addr != '0 &&
                   (idex_rd_addr == rs_addr || idex_rd_addr == rt_addr);

    assign ifid_flush = jump || redirect;

    // A stall leaves a bubble behind the load
    assign idex_flush = redirect || stall;

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                  clk,
    input  wire                  reset,
    input  wire cpu_pkg::idex_t  idex,
    input  wire cpu_pkg::wb_t    wb,
    output cpu_pkg::exmem_t      exmem,
    output logic                 redirect,
    output cpu_pkg::pc_t         redirect_target
);

    cpu_pkg::fwd_sel_e a_sel;
    cpu_pkg::fwd_sel_e b_sel;
    cpu_pkg::data_t    op_a;
    cpu_pkg::data_t    op_b;
    cpu_pkg::data_t    alu_b;
    cpu_pkg::data_t    alu_res;

    forward_unit fwd_i (
        .rs_addr ( idex.rs_addr ),
        .rt_addr ( idex.rt_addr ),
        .exmem   ( exmem        ),
        .wb      ( wb           ),
        .a_sel   ( a_sel        ),
        .b_sel   ( b_sel        )
    );

    //////////////////////////////////////////////////////////////////////
    // Operands and ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (a_sel)
            cpu_pkg::FWD_EXMEM: op_a = exmem.alu_res;
            cpu_pkg::FWD_MEMWB: op_a = wb.data;
            default:            op_a = idex.rs_data;
        endcase
        case (b_sel)
            cpu_pkg::FWD_EXMEM: op_b = exmem.alu_res;
            cpu_pkg::FWD_MEMWB: op_b = wb.data;
            default:            op_b = idex.rt_data;
        endcase
    end

    assign alu_b = idex.ctrl.alu_src_imm ? idex.imm : op_b;

    always_comb begin
        case (idex.ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_res = op_a + alu_b;
            cpu_pkg::ALU_SUB: alu_res = op_a - alu_b;
            cpu_pkg::ALU_AND: alu_res = op_a & alu_b;
            cpu_pkg::ALU_OR:  alu_res = op_a | alu_b;
            cpu_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
            cpu_pkg::ALU_LUI: alu_res = alu_b;
            default:          alu_res = '0;
        endcase
    end

    // Taken when equality matches the beq or bne sense
    assign redirect        = idex.ctrl.branch && ((op_a == op_b) != idex.ctrl.branch_ne);
    assign redirect_target = idex.pc_4 + {idex.imm[29:0], 2'b00};

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            exmem.reg_write <= 1'b0;
            exmem.mem_read  <= 1'b0;
            exmem.mem_write <= 1'b0;
        end else begin
            exmem.reg_write <= idex.ctrl.reg_write;
            exmem.mem_read  <= idex.ctrl.mem_read;
            exmem.mem_write <= idex.ctrl.mem_write;
        end
        exmem.alu_res    <= alu_res;
        exmem.store_data <= op_b;
        exmem.rd_addr    <= idex.rd_addr;
    end

endmodule

`default_nettype wire

//--- design/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  wire cpu_pkg::reg_addr_t rs_addr,
    input  wire cpu_pkg::reg_addr_t rt_addr,
    input  wire cpu_pkg::exmem_t    exmem,
    input  wire cpu_pkg::wb_t       wb,
    output cpu_pkg::fwd_sel_e       a_sel,
    output cpu_pkg::fwd_sel_e       b_sel
);

    // Newest producer wins; a load in EX/MEM has already cost a stall
    function automatic cpu_pkg::fwd_sel_e pick(input cpu_pkg::reg_addr_t addr);
        cpu_pkg::fwd_sel_e sel;
        if (exmem.reg_write && !exmem.mem_read && exmem.rd_addr != '0 &&
                exmem.rd_addr == addr) begin
            sel = cpu_pkg::FWD_EXMEM;
        end else if (wb.reg_write && wb.rd_addr != '0 && wb.rd_addr == addr) begin
            sel = cpu_pkg::FWD_MEMWB;
        end else begin
            sel = cpu_pkg::FWD_IDEX;
        end
        return sel;
    endfunction

    always_comb begin
        a_sel = pick(rs_addr);
        b_sel = pick(rt_addr);
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     reset,
    input  wire cpu_pkg::wb_t       wb,
    input  wire cpu_pkg::reg_addr_t rs_addr,
    input  wire cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::data_t          rs_data,
    output cpu_pkg::data_t          rt_data
);

    cpu_pkg::data_t regs [1:31];

    // Register 0 reads zero, a same-cycle write passes straight through
    function automatic cpu_pkg::data_t read_port(input cpu_pkg::reg_addr_t addr);
        cpu_pkg::data_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.reg_write && wb.rd_addr == addr) begin
            value = wb.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd_addr != '0) begin
            regs[wb.rd_addr] <= wb.data;
        end
    end

endmodule

`default_nettype wire

//--- design/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire cpu_pkg::instr_t instr,
    input  wire cpu_pkg::pc_t    pc_4,
    output cpu_pkg::ctrl_t       ctrl,
    output cpu_pkg::data_t       imm,
    output cpu_pkg::reg_addr_t   rs_addr,
    output cpu_pkg::reg_addr_t   rt_addr,
    output cpu_pkg::reg_addr_t   rd_addr,
    output cpu_pkg::pc_t         jump_target
);

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       use_rs;
    logic       use_rt;
    logic       dest_rd;

    assign opcode      = instr[31:26];
    assign funct       = instr[5:0];
    assign jump_target = {pc_4[31:28], instr[25:0], 2'b00};

    // Unused source fields read as register 0, so they never stall
    assign rs_addr = use_rs ? instr[25:21] : '0;
    assign rt_addr = use_rt ? instr[20:16] : '0;
    assign rd_addr = dest_rd ? instr[15:11] : instr[20:16];

    always_comb begin
        ctrl    = '0;
        imm     = {{16{instr[15]}}, instr[15:0]};
        use_rs  = 1'b0;
        use_rt  = 1'b0;
        dest_rd = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dest_rd = 1'b1;
                if (funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT}) begin
                    ctrl.reg_write = 1'b1;
                    use_rs         = 1'b1;
                    use_rt         = 1'b1;
                end
                case (funct)
                    FN_SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
                    FN_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
                    FN_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
                    FN_SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
                    default: ctrl.alu_op = cpu_pkg::ALU_ADD;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = (opcode == OP_LW);
                ctrl.alu_src_imm = 1'b1;
                use_rs           = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                use_rs           = 1'b1;
                use_rt           = 1'b1;
            end
            OP_ORI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = cpu_pkg::ALU_OR;
                imm              = {16'h0000, instr[15:0]};
                use_rs           = 1'b1;
            end
            OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = cpu_pkg::ALU_LUI;
                imm              = {instr[15:0], 16'h0000};
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (opcode == OP_BNE);
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::pc_t RESET_PC = '0
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  stall,
    input  wire                  flush,
    input  wire                  jump,
    input  wire cpu_pkg::pc_t    jump_target,
    input  wire                  redirect,
    input  wire cpu_pkg::pc_t    redirect_target,
    input  wire cpu_pkg::instr_t imem_data,
    output cpu_pkg::pc_t         imem_addr,
    output cpu_pkg::instr_t      ifid_instr,
    output cpu_pkg::pc_t         ifid_pc_4
);

    cpu_pkg::pc_t pc;
    cpu_pkg::pc_t pc_plus_4;

    assign imem_addr = pc;
    assign pc_plus_4 = pc + 32'd4;

    // Branch redirect first, then jump, then sequential
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_target;
        end else if (!stall) begin
            if (jump) begin
                pc <= jump_target;
            end else begin
                pc <= pc_plus_4;
            end
        end
    end

    // Zero word in IF/ID decodes as a no-op
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ifid_instr <= '0;
            ifid_pc_4  <= '0;
        end else if (!stall) begin
            ifid_instr <= imem_data;
            ifid_pc_4  <= pc_plus_4;
        end
    end

endmodule

`default_nettype wire

//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Widths with a meaning
    typedef logic [31:0] data_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_e;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FWD_IDEX  = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        alu_op_e alu_op;
        logic    branch;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        pc_t       pc_4;
        data_t     rs_data;
        data_t     rt_data;
        data_t     imm;
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t rd_addr;
    } idex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        data_t     alu_res;
        data_t     store_data;
        reg_addr_t rd_addr;
    } exmem_t;

    // Register file write port, also seen by forwarding
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd_addr;
        data_t     data;
    } wb_t;

    typedef struct packed {
        logic  read;
        logic  write;
        data_t addr;
        data_t wdata;
    } dmem_req_t;

endpackage

`default_nettype wire
